/* Bender.yml */
package:
  name: postproc

sources:
  - source/dsp_pkg.sv
  - source/apb_pkg.sv
  - source/apb_regs.sv
  - source/residual_calc.sv
  - source/sliding_detector.sv
  - source/bit_corrector.sv
  - source/postproc_top.sv
  - target: simulation
    files:
      - testbench/postproc_props.sv
      - testbench/tb_checker.sv
      - testbench/tb_top.sv

/* source/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    parameter int ADDR_BITS = 8;
    parameter int DATA_BITS = 32;

    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [ADDR_BITS-1:0] paddr;
        logic [DATA_BITS-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apb_rsp_t;

    typedef enum logic [ADDR_BITS-1:0] {
        REG_CTRL  = 8'h00,
        REG_TAP0  = 8'h04,
        REG_TAP1  = 8'h08,
        REG_TAP2  = 8'h0C,
        REG_TAP3  = 8'h10,
        REG_COUNT = 8'h14 // read only.
    } reg_addr_e;

endpackage

`default_nettype wire

/* source/apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output dsp_pkg::tap_set_t taps,
    output logic              enable,
    input  logic              block_done
);

    logic        access;      // access phase of an APB transfer.
    logic        addr_hit;
    logic [31:0] rdata;
    logic [31:0] block_count;

    assign access = apb_req.psel && apb_req.penable;

    // taps read back sign extended, the way they are used in the datapath.
    always_comb begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (apb_req.paddr)
            apb_pkg::REG_CTRL:  rdata = {31'b0, enable};
            apb_pkg::REG_TAP0:  rdata = 32'($signed(taps.tap[0]));
            apb_pkg::REG_TAP1:  rdata = 32'($signed(taps.tap[1]));
            apb_pkg::REG_TAP2:  rdata = 32'($signed(taps.tap[2]));
            apb_pkg::REG_TAP3:  rdata = 32'($signed(taps.tap[3]));
            apb_pkg::REG_COUNT: rdata = block_count;
            default:            addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            taps   <= '0;
            enable <= 1'b0;
        end else if (access && apb_req.pwrite) begin
            case (apb_req.paddr)
                apb_pkg::REG_CTRL: enable <= apb_req.pwdata[0];
                apb_pkg::REG_TAP0: taps.tap[0] <= apb_req.pwdata[dsp_pkg::TAP_BITS-1:0];
                apb_pkg::REG_TAP1: taps.tap[1] <= apb_req.pwdata[dsp_pkg::TAP_BITS-1:0];
                apb_pkg::REG_TAP2: taps.tap[2] <= apb_req.pwdata[dsp_pkg::TAP_BITS-1:0];
                apb_pkg::REG_TAP3: taps.tap[3] <= apb_req.pwdata[dsp_pkg::TAP_BITS-1:0];
                default: ; // the counter is read only, unmapped writes do nothing.
            endcase
        end
    end

    // one count per block taken from the output port, wrapping at 32 bits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            block_count <= '0;
        end else if (block_done) begin
            block_count <= block_count + 32'd1;
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;                // no wait states.
    assign apb_rsp.pslverr = access && !addr_hit;

endmodule : apb_regs

`default_nettype wire

/* source/bit_corrector.sv */
`timescale 1ns/1ns
`default_nettype none

module bit_corrector #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stage_valid,
    input  dsp_pkg::stage_t           stage,
    input  dsp_pkg::hyp_e [WIDTH-1:0] pos,
    input  logic                      enable,
    output logic                      advance,
    output logic                      out_valid,
    input  logic                      out_ready,
    output dsp_pkg::block_out_t       out_blk,
    output logic                      block_done
);

    localparam int N = WIDTH * DEPTH;

    logic [N-1:0]              flips;
    dsp_pkg::hyp_e [WIDTH-1:0] hyp;

    // Neighbouring positions may name the same bit.
    // The XOR makes two such flips cancel.
    always_comb begin
        flips = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (enable) begin
                hyp[i] = pos[i];
            end else begin
                hyp[i] = dsp_pkg::HYP_NONE;
            end
            case (hyp[i])
                dsp_pkg::HYP_HERE: flips[i] = flips[i] ^ 1'b1;
                dsp_pkg::HYP_NEXT: flips[i+1] = flips[i+1] ^ 1'b1;
                dsp_pkg::HYP_BOTH: begin
                    flips[i]   = flips[i] ^ 1'b1;
                    flips[i+1] = flips[i+1] ^ 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign advance    = !out_valid || out_ready; // register free or being read.
    assign block_done = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && stage_valid) begin
            out_blk.bits <= stage.bits ^ flips;
            out_blk.hyp  <= hyp;
        end
    end

endmodule : bit_corrector

`default_nettype wire

/* source/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

    parameter int SEQ_LENGTH = 3;  // channel memory in bits.
    parameter int WIDTH      = 16; // detector positions per block.
    parameter int DEPTH      = 2;  // block length is WIDTH * DEPTH bits.
    parameter int ERR_BITS   = 8;
    parameter int TAP_BITS   = 8;
    parameter int MAX_BITS   = 8;
    parameter int BLK_BITS   = WIDTH * DEPTH;

    typedef logic signed [ERR_BITS+1:0] sample_t;

    // tap[0] weights the current bit, tap[t] the bit t positions earlier.
    typedef struct packed {
        logic [SEQ_LENGTH:0][TAP_BITS-1:0] tap;
    } tap_set_t;

    typedef struct packed {
        sample_t [BLK_BITS-1:0] samples;
        logic    [BLK_BITS-1:0] bits;
        logic    [SEQ_LENGTH-1:0] history; // history[SEQ_LENGTH-1] is the bit just before bits[0].
    } block_in_t;

    typedef enum logic [1:0] {
        HYP_NONE = 2'd0,
        HYP_HERE = 2'd1,
        HYP_NEXT = 2'd2,
        HYP_BOTH = 2'd3
    } hyp_e;

    typedef struct packed {
        logic [BLK_BITS-1:0] bits;
        hyp_e [WIDTH-1:0]    hyp;
    } block_out_t;

    // contents of the first pipeline register.
    typedef struct packed {
        logic [BLK_BITS-1:0]               bits;
        logic [BLK_BITS-1:0][ERR_BITS-1:0] resid;
    } stage_t;

endpackage

`default_nettype wire

/* source/postproc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module postproc_top #(
    parameter int SEQ_LENGTH = dsp_pkg::SEQ_LENGTH,
    parameter int WIDTH      = dsp_pkg::WIDTH,
    parameter int DEPTH      = dsp_pkg::DEPTH,
    parameter int ERR_BITS   = dsp_pkg::ERR_BITS,
    parameter int TAP_BITS   = dsp_pkg::TAP_BITS,
    parameter int MAX_BITS   = dsp_pkg::MAX_BITS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_pkg::apb_req_t   apb_req,
    output apb_pkg::apb_rsp_t   apb_rsp,
    input  logic                in_valid,
    output logic                in_ready,
    input  dsp_pkg::block_in_t  in_blk,
    output logic                out_valid,
    input  logic                out_ready,
    output dsp_pkg::block_out_t out_blk
);

    dsp_pkg::tap_set_t         taps;
    dsp_pkg::stage_t           stage;
    dsp_pkg::hyp_e [WIDTH-1:0] pos;
    logic                      enable;
    logic                      block_done;
    logic                      advance;      // stage two can take the block in stage one.
    logic                      stage_valid;

    apb_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .taps       (taps),
        .enable     (enable),
        .block_done (block_done)
    );

    residual_calc #(
        .SEQ_LENGTH (SEQ_LENGTH),
        .WIDTH      (WIDTH),
        .DEPTH      (DEPTH),
        .ERR_BITS   (ERR_BITS)
    ) resid_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_blk      (in_blk),
        .taps        (taps),
        .advance     (advance),
        .stage_valid (stage_valid),
        .stage       (stage)
    );

    // The detector sits between the two registers.
    // Its metric outputs are only for debug.
    sliding_detector #(
        .seq_length             (SEQ_LENGTH),
        .width                  (WIDTH),
        .est_error_bitwidth     (ERR_BITS),
        .est_channel_bitwidth   (TAP_BITS),
        .max_bitwidth           (MAX_BITS),
        .sliding_detector_depth (DEPTH)
    ) det_i (
        .errstream     (stage.resid),
        .bitstream     (stage.bits),
        .channel       (taps.tap),
        .sqr_inj_error (),
        .mmse_err_pos  (pos)
    );

    bit_corrector #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) corr_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .stage       (stage),
        .pos         (pos),
        .enable      (enable),
        .advance     (advance),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_blk     (out_blk),
        .block_done  (block_done)
    );

endmodule : postproc_top

`default_nettype wire

/* source/residual_calc.sv */
`timescale 1ns/1ns
`default_nettype none

module residual_calc #(
    parameter int SEQ_LENGTH = 3,
    parameter int WIDTH      = 16,
    parameter int DEPTH      = 2,
    parameter int ERR_BITS   = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  dsp_pkg::block_in_t in_blk,
    input  dsp_pkg::tap_set_t  taps,
    input  logic               advance,
    output logic               stage_valid,
    output dsp_pkg::stage_t    stage
);

    localparam int N       = WIDTH * DEPTH;
    localparam int ACC_W   = ERR_BITS + 6; // room for a sample and SEQ_LENGTH+1 taps.
    localparam int SAT_MAX = 2 ** (ERR_BITS - 1) - 1;
    localparam int SAT_MIN = -(2 ** (ERR_BITS - 1));

    logic [N+SEQ_LENGTH-1:0]    ext_bits;
    logic [N-1:0][ERR_BITS-1:0] resid;
    logic                       load;

    // bit k of the block sits at ext_bits[k + SEQ_LENGTH], the history below it.
    assign ext_bits = {in_blk.bits, in_blk.history};
    assign in_ready = !stage_valid || advance;
    assign load     = in_valid && in_ready;

    // a decision of 1 means +1 on the channel, a 0 means -1.
    always_comb begin
        logic signed [ACC_W-1:0] acc;
        for (int k = 0; k < N; k++) begin
            acc = $signed(in_blk.samples[k]);
            for (int t = 0; t <= SEQ_LENGTH; t++) begin
                if (ext_bits[k - t + SEQ_LENGTH]) begin
                    acc = acc - $signed(taps.tap[t]);
                end else begin
                    acc = acc + $signed(taps.tap[t]);
                end
            end
            if (acc > SAT_MAX) begin
                resid[k] = ERR_BITS'(SAT_MAX);
            end else if (acc < SAT_MIN) begin
                resid[k] = ERR_BITS'(SAT_MIN);
            end else begin
                resid[k] = acc[ERR_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (in_ready) begin
            stage_valid <= in_valid; // empties when the block moves on with nothing behind it.
        end
    end

    // taps in effect at the accepting edge are the ones baked into the residuals.
    always_ff @(posedge clk) begin
        if (load) begin
            stage.bits  <= in_blk.bits;
            stage.resid <= resid;
        end
    end

endmodule : residual_calc

`default_nettype wire

/* source/sliding_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module sliding_detector #(
    parameter int seq_length             = 3,
    parameter int width                  = 16,
    parameter int est_error_bitwidth     = 8,
    parameter int est_channel_bitwidth   = 8,
    parameter int max_bitwidth           = 8,
    parameter int sliding_detector_depth = 2
) (
    input  logic [width*sliding_detector_depth-1:0][est_error_bitwidth-1:0] errstream,
    input  logic [width*sliding_detector_depth-1:0]                         bitstream,
    input  logic [seq_length:0][est_channel_bitwidth-1:0]                   channel,
    output logic [3:0][width-1:0][seq_length-1:0][max_bitwidth*2+3:0]       sqr_inj_error,
    output dsp_pkg::hyp_e [width-1:0]                                       mmse_err_pos
);

    localparam int SUM_W = max_bitwidth + 2;
    localparam int SQR_W = max_bitwidth * 2 + 4;
    localparam int MSE_W = SQR_W + $clog2(seq_length + 1);

    // inverse error vector for each position, signed by the detected bit.
    logic signed [max_bitwidth:0] iev [width:0][seq_length:0];
    logic [MSE_W-1:0]             mse_err [3:0][width-1:0];

    always_comb begin
        for (int i = 0; i <= width; i++) begin
            for (int j = 0; j <= seq_length; j++) begin
                iev[i][j] = bitstream[i] ? $signed(channel[j]) : -$signed(channel[j]);
            end
        end
    end

    // Position i is judged on samples i+1 to i+seq_length.
    // An error at bit i reaches sample i+1+j through tap j+1.
    // An error at bit i+1 reaches it through tap j.
    always_comb begin
        logic signed [SUM_W-1:0] term [3:0];
        logic signed [SQR_W-1:0] sq;
        for (int i = 0; i < width; i++) begin
            for (int h = 0; h < 4; h++) begin
                mse_err[h][i] = '0;
            end
            for (int j = 0; j < seq_length; j++) begin
                term[0] = $signed(errstream[i+j+1]);
                term[1] = $signed(errstream[i+j+1]) + iev[i][j+1];
                term[2] = $signed(errstream[i+j+1]) + iev[i+1][j];
                term[3] = $signed(errstream[i+j+1]) + iev[i][j+1] + iev[i+1][j];
                for (int h = 0; h < 4; h++) begin
                    sq = term[h] * term[h];
                    sqr_inj_error[h][i][j] = sq;
                    mse_err[h][i] = mse_err[h][i] + MSE_W'(sq);
                end
            end
        end
    end

    always_comb begin
        logic [MSE_W-1:0] best;
        for (int i = 0; i < width; i++) begin
            best            = mse_err[0][i];
            mmse_err_pos[i] = dsp_pkg::HYP_NONE;
            for (int h = 1; h < 4; h++) begin
                if (mse_err[h][i] < best) begin // strict, so a tie keeps the lower code.
                    best            = mse_err[h][i];
                    mmse_err_pos[i] = dsp_pkg::hyp_e'(h);
                end
            end
        end
    end

endmodule : sliding_detector

`default_nettype wire

/* src.f */
source/dsp_pkg.sv
source/apb_pkg.sv
source/apb_regs.sv
source/residual_calc.sv
source/sliding_detector.sv
source/bit_corrector.sv
source/postproc_top.sv
testbench/postproc_props.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* testbench/postproc_props.sv */
`timescale 1ns/1ns
`default_nettype none

module postproc_props (
    input logic                clk,
    input logic                rst_n,
    input apb_pkg::apb_req_t   apb_req,
    input apb_pkg::apb_rsp_t   apb_rsp,
    input logic                out_valid,
    input logic                out_ready,
    input dsp_pkg::block_out_t out_blk
);

    int failures = 0; // assertion failures seen so far.

    // a stalled output keeps both its valid and its data.
    stalled_output_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_blk)
    ) else begin
        failures++;
        $error("out_blk changed while the output was stalled.");
    end

    reset_clears_valid: assert property (
        @(posedge clk) !rst_n |=> !out_valid
    ) else begin
        failures++;
        $error("out_valid was high right after a reset cycle.");
    end

    slverr_only_on_access: assert property (
        @(posedge clk) apb_rsp.pslverr |-> apb_req.psel && apb_req.penable
    ) else begin
        failures++;
        $error("pslverr was high outside an APB access phase.");
    end

endmodule : postproc_props

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter int SEQ_LENGTH = 3,
    parameter int WIDTH      = 16,
    parameter int DEPTH      = 2,
    parameter int ERR_BITS   = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_pkg::apb_req_t   apb_req,
    input  apb_pkg::apb_rsp_t   apb_rsp,
    input  logic                in_valid,
    input  logic                in_ready,
    input  dsp_pkg::block_in_t  in_blk,
    input  logic                out_valid,
    input  logic                out_ready,
    input  dsp_pkg::block_out_t out_blk,
    output int                  error_count,
    output int                  check_count,
    output int                  pending
);

    localparam int N       = WIDTH * DEPTH;
    localparam int SAT_MAX = 2 ** (ERR_BITS - 1) - 1;
    localparam int SAT_MIN = -(2 ** (ERR_BITS - 1));

    dsp_pkg::block_out_t expected_q [$];
    dsp_pkg::tap_set_t   shadow_taps;   // register model kept from the APB writes seen.
    logic                shadow_enable;
    logic [31:0]         shadow_count;

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 0;
    end

    // residuals, four metrics per position, argmin and the combined flips.
    function automatic dsp_pkg::block_out_t predict(input dsp_pkg::block_in_t blk,
                                                   input dsp_pkg::tap_set_t taps, input logic en);
        dsp_pkg::block_out_t res;
        int                  resid [N];
        int                  tap [SEQ_LENGTH+1];
        int                  metric [4];
        int                  acc;
        int                  e;
        int                  s_here;
        int                  s_next;
        int                  best;
        logic                b;
        logic [N-1:0]        flips;
        for (int t = 0; t <= SEQ_LENGTH; t++) tap[t] = $signed(taps.tap[t]);
        for (int k = 0; k < N; k++) begin
            acc = $signed(blk.samples[k]);
            for (int t = 0; t <= SEQ_LENGTH; t++) begin
                b   = (k - t >= 0) ? blk.bits[k-t] : blk.history[SEQ_LENGTH+k-t];
                acc = acc - (b ? tap[t] : -tap[t]);
            end
            resid[k] = (acc > SAT_MAX) ? SAT_MAX : (acc < SAT_MIN) ? SAT_MIN : acc;
        end
        flips = '0;
        for (int i = 0; i < WIDTH; i++) begin
            s_here = blk.bits[i] ? 1 : -1;
            s_next = blk.bits[i+1] ? 1 : -1;
            for (int h = 0; h < 4; h++) begin
                metric[h] = 0;
                for (int j = 0; j < SEQ_LENGTH; j++) begin
                    e = resid[i+j+1] + (h[0] ? s_here * tap[j+1] : 0) + (h[1] ? s_next * tap[j] : 0);
                    metric[h] = metric[h] + e * e;
                end
            end
            best = 0;
            for (int h = 1; h < 4; h++) if (metric[h] < metric[best]) best = h;
            if (!en) best = 0;
            res.hyp[i] = dsp_pkg::hyp_e'(best);
            if (best == 1 || best == 3) flips[i] = ~flips[i];
            if (best == 2 || best == 3) flips[i+1] = ~flips[i+1];
        end
        res.bits = blk.bits ^ flips;
        return res;
    endfunction

    function automatic logic is_mapped(input logic [7:0] addr);
        case (addr)
            apb_pkg::REG_CTRL, apb_pkg::REG_TAP0, apb_pkg::REG_TAP1, apb_pkg::REG_TAP2,
            apb_pkg::REG_TAP3, apb_pkg::REG_COUNT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] reg_value(input logic [7:0] addr);
        int v;
        v = 0;
        case (addr)
            apb_pkg::REG_CTRL:  v = shadow_enable;
            apb_pkg::REG_TAP0:  v = $signed(shadow_taps.tap[0]);
            apb_pkg::REG_TAP1:  v = $signed(shadow_taps.tap[1]);
            apb_pkg::REG_TAP2:  v = $signed(shadow_taps.tap[2]);
            apb_pkg::REG_TAP3:  v = $signed(shadow_taps.tap[3]);
            apb_pkg::REG_COUNT: v = shadow_count;
            default: ;
        endcase
        return v;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        dsp_pkg::block_out_t exp_blk;
        logic                access;
        access = apb_req.psel && apb_req.penable;
        if (!rst_n) begin
            shadow_taps   = '0;
            shadow_enable = 1'b0;
            shadow_count  = '0;
            expected_q.delete();
        end else begin
            if (access) begin
                compare("apb_rsp.pready", 1'b1, apb_rsp.pready);
                compare("apb_rsp.pslverr", !is_mapped(apb_req.paddr), apb_rsp.pslverr);
                if (!apb_req.pwrite && is_mapped(apb_req.paddr)) begin
                    compare("apb_rsp.prdata", reg_value(apb_req.paddr), apb_rsp.prdata);
                end
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(predict(in_blk, shadow_taps, shadow_enable));
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("an output block was accepted at %0t with no input block outstanding",
                             $time);
                end else begin
                    exp_blk = expected_q.pop_front();
                    compare("out_blk.bits", exp_blk.bits, out_blk.bits);
                    compare("out_blk.hyp", exp_blk.hyp, out_blk.hyp);
                end
                shadow_count = shadow_count + 32'd1;
            end
            // writes take effect after this edge, so they are applied last.
            if (access && apb_req.pwrite) begin
                case (apb_req.paddr)
                    apb_pkg::REG_CTRL: shadow_enable = apb_req.pwdata[0];
                    apb_pkg::REG_TAP0: shadow_taps.tap[0] = apb_req.pwdata[7:0];
                    apb_pkg::REG_TAP1: shadow_taps.tap[1] = apb_req.pwdata[7:0];
                    apb_pkg::REG_TAP2: shadow_taps.tap[2] = apb_req.pwdata[7:0];
                    apb_pkg::REG_TAP3: shadow_taps.tap[3] = apb_req.pwdata[7:0];
                    default: ;
                endcase
            end
        end
        pending = expected_q.size();
    end

endmodule : tb_checker

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int SEQ_LENGTH   = dsp_pkg::SEQ_LENGTH;
    localparam int WIDTH        = dsp_pkg::WIDTH;
    localparam int DEPTH        = dsp_pkg::DEPTH;
    localparam int ERR_BITS     = dsp_pkg::ERR_BITS;
    localparam int TAP_BITS     = dsp_pkg::TAP_BITS;
    localparam int MAX_BITS     = dsp_pkg::MAX_BITS;
    localparam int N            = WIDTH * DEPTH;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int BLOCKS_TOTAL = 8 + 12 + 32 + 40; // blocks over all tests.
    localparam int APB_ACCESSES = 32;
    localparam int WATCHDOG_CYCLES = BLOCKS_TOTAL * 20 + APB_ACCESSES * 3 + RESET_CYCLES;

    logic                clk;
    logic                rst_n;
    apb_pkg::apb_req_t   apb_req;
    apb_pkg::apb_rsp_t   apb_rsp;
    logic                in_valid;
    logic                in_ready;
    dsp_pkg::block_in_t  in_blk;
    logic                out_valid;
    logic                out_ready;
    dsp_pkg::block_out_t out_blk;
    logic                stall_mode;  // random back-pressure on the output port.
    int                  tap_val [SEQ_LENGTH+1];
    int                  chk_errors;
    int                  chk_checks;
    int                  chk_pending;
    int                  tests_run;
    int                  tests_failed;
    int                  errors_at_start;

    postproc_top #(
        .SEQ_LENGTH (SEQ_LENGTH),
        .WIDTH      (WIDTH),
        .DEPTH      (DEPTH),
        .ERR_BITS   (ERR_BITS),
        .TAP_BITS   (TAP_BITS),
        .MAX_BITS   (MAX_BITS)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_blk    (in_blk),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_blk   (out_blk)
    );

    tb_checker #(
        .SEQ_LENGTH (SEQ_LENGTH),
        .WIDTH      (WIDTH),
        .DEPTH      (DEPTH),
        .ERR_BITS   (ERR_BITS)
    ) checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_blk      (in_blk),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_blk     (out_blk),
        .error_count (chk_errors),
        .check_count (chk_checks),
        .pending     (chk_pending)
    );

    bind postproc_top postproc_props props_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_blk   (out_blk)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        #1;
        out_ready = stall_mode ? (($urandom % 3) != 0) : 1'b1;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles, the DUT stopped delivering blocks",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // compare errors and assertion failures together.
    function automatic int total_errors();
        return chk_errors + dut_i.props_i.failures;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        tick();
        apb_req.penable = 1'b1;
        forever begin
            @(posedge clk);
            if (apb_rsp.pready) break;
        end
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [7:0] addr);
        apb_access(1'b0, addr, 32'h0); // the checker compares prdata.
    endtask

    task automatic program_taps(input int t0, input int t1, input int t2, input int t3);
        tap_val[0] = t0;
        tap_val[1] = t1;
        tap_val[2] = t2;
        tap_val[3] = t3;
        for (int t = 0; t <= SEQ_LENGTH; t++) begin
            apb_write(8'(apb_pkg::REG_TAP0 + 4 * t), 32'(tap_val[t]));
        end
    endtask

    // noiseless channel output for bit k, with history bits before the block.
    function automatic int ideal_sample(input logic [N-1:0] bits, input logic [SEQ_LENGTH-1:0] hist,
                                        input int k);
        int   sum;
        logic b;
        sum = 0;
        for (int t = 0; t <= SEQ_LENGTH; t++) begin
            b   = (k - t >= 0) ? bits[k-t] : hist[SEQ_LENGTH+k-t];
            sum = sum + (b ? tap_val[t] : -tap_val[t]);
        end
        return sum;
    endfunction

    function automatic dsp_pkg::block_in_t build_block(input int noise, input int flips,
                                                      input bit wild);
        dsp_pkg::block_in_t blk;
        logic [N-1:0]       truth;
        int                 v;
        int                 pos;
        int                 pos2;
        for (int k = 0; k < N; k++) begin
            truth[k] = $urandom % 2;
        end
        for (int h = 0; h < SEQ_LENGTH; h++) begin
            blk.history[h] = $urandom % 2;
        end
        for (int k = 0; k < N; k++) begin
            v = ideal_sample(truth, blk.history, k);
            if (noise > 0) v = v + int'($urandom % (2 * noise + 1)) - noise;
            if (wild) v = int'($urandom % 1024) - 512; // full sample range, mostly saturates.
            blk.samples[k] = dsp_pkg::sample_t'(v);
        end
        blk.bits = truth;
        // decision errors go where the detector window can see them.
        pos  = 1 + $urandom % (WIDTH - 2);
        pos2 = pos + 1 + $urandom % 2;
        if (flips > 0) blk.bits[pos] = ~blk.bits[pos];
        if (flips > 1) blk.bits[pos2] = ~blk.bits[pos2];
        return blk;
    endfunction

    task automatic send_block(input dsp_pkg::block_in_t blk);
        in_blk   = blk;
        in_valid = 1'b1;
        forever begin
            @(posedge clk);
            if (in_ready) break;
        end
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (chk_pending != 0) tick();
        tick();
    endtask

    task automatic finish_test(input string name);
        int errs;
        wait_idle();
        errs = total_errors() - errors_at_start;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %0d %-14s %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "FAILED",
                 errs);
        errors_at_start = total_errors();
    endtask

    initial begin
        void'($urandom(32'hc9b1));
        clk             = 1'b0;
        rst_n           = 1'b0;
        apb_req         = '0;
        in_valid        = 1'b0;
        in_blk          = '0;
        out_ready       = 1'b1;
        stall_mode      = 1'b0;
        tests_run       = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        for (int t = 0; t <= SEQ_LENGTH; t++) tap_val[t] = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        for (int t = 0; t <= SEQ_LENGTH; t++) apb_read(8'(apb_pkg::REG_TAP0 + 4 * t));
        apb_read(apb_pkg::REG_CTRL);
        program_taps(24, 40, -16, 8);
        apb_write(apb_pkg::REG_CTRL, 32'h1);
        for (int t = 0; t <= SEQ_LENGTH; t++) apb_read(8'(apb_pkg::REG_TAP0 + 4 * t));
        apb_read(apb_pkg::REG_CTRL);
        apb_read(8'h18);                  // past the last register.
        apb_write(8'h2c, 32'hdead_beef);
        apb_write(apb_pkg::REG_COUNT, 32'h55);
        apb_read(apb_pkg::REG_COUNT);
        finish_test("registers");

        repeat (8) send_block(build_block(0, 0, 1'b0));
        finish_test("clean");

        for (int b = 0; b < 12; b++) send_block(build_block(0, 1 + b % 2, 1'b0));
        finish_test("injected");

        apb_write(apb_pkg::REG_CTRL, 32'h0);
        for (int b = 0; b < 16; b++) send_block(build_block(10, b % 3, b % 4 == 3));
        wait_idle();
        apb_write(apb_pkg::REG_CTRL, 32'h1);
        for (int b = 0; b < 16; b++) send_block(build_block(10, b % 3, b % 4 == 3));
        finish_test("random");

        stall_mode = 1'b1;
        for (int b = 0; b < 40; b++) begin
            repeat ($urandom % 3) tick(); // gaps on the input side.
            send_block(build_block(8, $urandom % 3, ($urandom % 5) == 0));
        end
        wait_idle();
        stall_mode = 1'b0;
        tick();
        apb_read(apb_pkg::REG_COUNT);
        finish_test("backpressure");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, chk_checks, total_errors());
        if (tests_failed == 0 && total_errors() == 0 && chk_checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_top

`default_nettype wire
